// ==== Makefile ====
# Verilator build for the SPI register block testbench.
# make compile builds the model, make run simulates it and checks run.log.

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module spi_regs_tb \
	  -f spi_regs.f --Mdir obj_dir -o spi_regs_tb

run: compile
	./obj_dir/spi_regs_tb | tee run.log
	grep -q "ALL TESTS PASSED" run.log

clean:
	rm -rf obj_dir run.log

// ==== bench/spi_regs_tb.sv ====
// Testbench for the SPI register block.
// Bit-bangs an SPI mode 0 master, keeps a reference model of the register
// map and the write-event slot, and checks every returned byte and event.
`timescale 1ns/100ps
`default_nettype none

module spi_regs_tb;

  import spi_regs_pkg::*;

  localparam byte_t       DEV_ID      = 8'h5c;  // not the default, proves the override
  localparam int          HALF        = 6;      // sck half-period in clk cycles
  localparam int          WAIT_LIMIT  = 400;    // cycles per wait loop
  localparam logic [31:0] SEED        = 32'hc2dd_b353;

  logic    clk = 1'b0;
  logic    rst;
  logic    ss;
  logic    sck;
  logic    mosi;
  logic    evt_ready = 1'b0; // driven by the ready pattern below
  logic    miso;
  logic    evt_valid;
  wr_evt_t evt;

  logic [31:0] data_seed  = SEED;
  logic [31:0] ready_seed = SEED;
  logic        stall      = 1'b0; // forces evt_ready low

  // reference model
  byte_t   mem [8];          // registers 0..7
  byte_t   frame_cnt = 8'd0;
  byte_t   wr_cnt    = 8'd0;
  logic    ovr       = 1'b0;
  wr_evt_t evt_q [$];        // events still owed by the DUT
  byte_t   last_rx;          // last byte of the latest frame

  spi_regs #(
    .DEVICE_ID (DEV_ID)
  ) dut0 (
    .clk       (clk),
    .rst       (rst),
    .ss        (ss),
    .sck       (sck),
    .mosi      (mosi),
    .evt_ready (evt_ready),
    .miso      (miso),
    .evt_valid (evt_valid),
    .evt       (evt)
  );

  always #4 clk = ~clk; // 8 ns period

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic byte_t next_rand();
    data_seed = lcg_next(data_seed);
    return data_seed[23:16]; // upper bits are the better ones
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_byte(input string name, input byte_t exp, input byte_t act);
    assert (act == exp)
      else abort_run($sformatf("FAIL %s: expected %02h, actual %02h", name, exp, act));
  endtask

  task automatic check_event(input string name, input wr_evt_t exp, input wr_evt_t act);
    assert (act == exp)
      else abort_run($sformatf("FAIL %s: expected %03h, actual %03h", name, exp, act));
  endtask

  function automatic byte_t model_read(input reg_addr_t a);
    byte_t v;
    case (a)
      4'd8:    v = DEV_ID;
      4'd9:    v = frame_cnt;
      4'd10:   v = wr_cnt;
      4'd11:   v = {7'd0, ovr}; // bit 0 overrun
      default: v = a[3] ? 8'h00 : mem[a[2:0]]; // 12..15 read zero
    endcase
    return v;
  endfunction

  function automatic void model_write(input reg_addr_t a, input byte_t d);
    wr_evt_t e;
    e.addr = a;
    e.data = d;
    if (!a[3]) begin // 8..15 ignore writes
      mem[a[2:0]] = d;
      wr_cnt      = wr_cnt + 8'd1;
      if (evt_q.size() != 0)
        ovr = 1'b1; // slot full, event lost
      else
        evt_q.push_back(e);
    end
  endfunction

  // random ready pattern, off while stalled
  always @(posedge clk) begin
    ready_seed <= lcg_next(ready_seed);
    evt_ready  <= !stall && ready_seed[20];
  end

  // event monitor, one expected entry per handshake
  always @(posedge clk) begin
    if (!rst && evt_valid && evt_ready) begin
      if (evt_q.size() == 0)
        abort_run("write event seen while none was expected");
      else begin
        check_event("write event", evt_q[0], evt);
        void'(evt_q.pop_front());
      end
    end
  end

  a_evt_stable: assert property (@(posedge clk) disable iff (rst)
    (evt_valid && !evt_ready) |=> $stable(evt))
    else abort_run("event changed while stalled");

  task automatic wait_events_drained();
    int n;
    n = 0;
    while ((evt_q.size() != 0 || evt_valid) && n < WAIT_LIMIT) begin
      @(posedge clk);
      n++;
    end
    if (evt_q.size() != 0 || evt_valid)
      abort_run("timeout waiting for write events to drain");
  endtask

  task automatic wait_event_valid();
    int n;
    n = 0;
    while (!evt_valid && n < WAIT_LIMIT) begin
      @(posedge clk);
      n++;
    end
    if (!evt_valid)
      abort_run("timeout waiting for evt_valid");
  endtask

  // one byte, msb first, miso taken at each sck rise
  task automatic spi_byte(input byte_t tx, output byte_t rx);
    byte_t sh;
    byte_t in;
    int    i;
    sh = tx;
    in = 8'h00;
    for (i = 0; i < 8; i++) begin
      mosi <= sh[7];
      repeat (HALF) @(posedge clk);
      in  = {in[6:0], miso}; // stable since the last fall
      sck <= 1'b1;
      repeat (HALF) @(posedge clk);
      sck <= 1'b0;
      sh  = {sh[6:0], 1'b0};
    end
    rx = in;
  endtask

  task automatic frame_start();
    ss <= 1'b0;
    repeat (HALF) @(posedge clk);
  endtask

  task automatic frame_stop();
    repeat (HALF) @(posedge clk);
    ss <= 1'b1;
    repeat (2 * HALF) @(posedge clk); // let frame_end land
    frame_cnt = frame_cnt + 8'd1;
  endtask

  task automatic do_frame(input string name, input logic is_wr, input reg_addr_t start,
                          input int nbytes);
    byte_t     cmd;
    byte_t     junk;
    byte_t     tx;
    byte_t     exp;
    byte_t     got;
    reg_addr_t a;
    int        k;
    junk = next_rand();
    cmd  = {is_wr, junk[6:4], start}; // bits 6:4 are don't care
    frame_start();
    spi_byte(cmd, got);
    check_byte($sformatf("%s id", name), DEV_ID, got);
    a = start;
    for (k = 0; k < nbytes; k++) begin
      if (!stall)
        wait_events_drained(); // keep the slot free
      tx  = next_rand();
      exp = model_read(a); // read value precedes this byte's write
      if (is_wr)
        model_write(a, tx);
      spi_byte(tx, got);
      check_byte($sformatf("%s addr %0d", name, a), exp, got);
      a = a + 4'd1; // wraps like the DUT
    end
    last_rx = got;
    frame_stop();
  endtask

  initial begin
    int    i;
    byte_t r;
    rst  = 1'b1;
    ss   = 1'b1;
    sck  = 1'b0;
    mosi = 1'b0;
    for (i = 0; i < 8; i++)
      mem[i] = 8'h00;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    check_byte("reset evt_valid", 8'h00, {7'd0, evt_valid});
    check_byte("reset miso", 8'h01, {7'd0, miso});

    do_frame("fill", 1'b1, 4'd0, 8);          // one event per register
    do_frame("upper write", 1'b1, 4'd5, 10);  // 8..14 ignored
    do_frame("wrap write", 1'b1, 4'd12, 8);   // 12..15 then 0..3
    do_frame("readback", 1'b0, 4'd3, 18);     // wraps past 15

    stall <= 1'b1;
    do_frame("stall write", 1'b1, 4'd2, 2);   // second event dropped
    wait_event_valid();
    check_event("stalled event", evt_q[0], evt);
    repeat (20) @(posedge clk); // stability assertion watches this
    stall <= 1'b0;
    wait_events_drained();
    do_frame("after stall", 1'b0, 4'd0, 12);
    do_frame("flags", 1'b0, 4'd11, 1);
    check_byte("overrun flag", 8'h01, {7'd0, last_rx[0]});

    for (i = 0; i < 4; i++) begin
      r = next_rand();
      do_frame("mixed", r[7], r[3:0], int'(r[5:4]) + 1);
    end
    do_frame("counters", 1'b0, 4'd9, 2);
    wait_events_drained();

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== hdl/spi_byte_io.sv ====
// SPI mode 0 slave byte shifter, msb first.
// ss, sck and mosi go through two-flop synchronizers into the clk domain.
// rx_done pulses once per received byte; tx_byte is taken while deselected
// and again in the cycle after each rx_done pulse.
`timescale 1ns/100ps
`default_nettype none

module spi_byte_io (
  input  wire                 clk,
  input  wire                 rst,
  input  wire                 ss,      // active low select
  input  wire                 sck,
  input  wire                 mosi,
  input  wire spi_regs_pkg::byte_t tx_byte, // next byte to shift out
  output logic                miso,
  output logic                sel,     // synced select, high while ss low
  output logic                rx_done, // one cycle per byte
  output spi_regs_pkg::byte_t rx_byte
);

  import spi_regs_pkg::*;

  logic  ss_m, ss_s;     // ss synchronizer
  logic  sck_m, sck_s;   // sck synchronizer
  logic  sck_old;        // previous synced sck
  logic  mosi_m, mosi_s; // mosi synchronizer
  logic  sck_rise;
  logic  sck_fall;
  logic  last_bit;       // 8th bit of the byte
  logic  load_q;         // reload slot, one cycle after rx_done
  logic  [2:0] bit_ct;
  byte_t shreg;          // shared rx/tx shift register
  byte_t shifted;

  assign sck_rise = sck_s & ~sck_old;
  assign sck_fall = ~sck_s & sck_old;
  assign last_bit = (bit_ct == 3'd7);
  assign shifted  = {shreg[6:0], mosi_s}; // msb first in
  assign sel      = ~ss_s;

  always_ff @(posedge clk) begin
    if (rst) begin
      ss_m    <= 1'b1; // start deselected
      ss_s    <= 1'b1;
      sck_m   <= 1'b0; // mode 0 idles low
      sck_s   <= 1'b0;
      sck_old <= 1'b0;
      mosi_m  <= 1'b0;
      mosi_s  <= 1'b0;
    end else begin
      ss_m    <= ss;
      ss_s    <= ss_m;
      sck_m   <= sck;
      sck_s   <= sck_m;
      sck_old <= sck_s;
      mosi_m  <= mosi;
      mosi_s  <= mosi_m;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      bit_ct  <= 3'd0;
      rx_done <= 1'b0;
      load_q  <= 1'b0;
      miso    <= 1'b1;
    end else begin
      rx_done <= 1'b0;
      load_q  <= rx_done; // controller has one cycle to settle tx_byte
      if (ss_s) begin
        bit_ct <= 3'd0; // realign on every frame
        if (!ss_m)
          miso <= shreg[7]; // first bit out as select arrives
        else
          miso <= 1'b1; // idle high while deselected
      end else if (sck_rise) begin
        bit_ct <= bit_ct + 3'd1;
        if (last_bit && !ss_m)
          rx_done <= 1'b1; // only if still selected next cycle
      end else if (sck_fall) begin
        miso <= shreg[7]; // mode 0 drives on falling edge
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ss_s || load_q)
      shreg <= tx_byte;
    else if (sck_rise)
      shreg <= shifted;
    if (!ss_s && sck_rise && last_bit)
      rx_byte <= shifted; // full byte captured
  end

  // a done pulse always belongs to an active frame
  a_done_in_frame: assert property (@(posedge clk) disable iff (rst)
    rx_done |-> sel);

endmodule

`default_nettype wire

// ==== hdl/spi_frame_ctrl.sv ====
// Frame controller for the SPI register block.
// Parses the command byte, walks the address upward after each data byte,
// picks the read data for the next byte out and issues register writes.
// Also owns the single-slot write-event output with overrun detection.
`timescale 1ns/100ps
`default_nettype none

module spi_frame_ctrl (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          sel,          // synced select
  input  wire                          rx_done,
  input  wire spi_regs_pkg::byte_t     rx_byte,
  input  wire spi_regs_pkg::byte_t     file_rd_data, // addresses 0..7
  input  wire spi_regs_pkg::byte_t     stat_rd_data, // addresses 8..15
  input  wire                          evt_ready,
  output spi_regs_pkg::byte_t          tx_byte,
  output spi_regs_pkg::reg_addr_t      rd_addr,
  output logic                         wr_en,
  output spi_regs_pkg::wr_evt_t        wr,
  output logic                         frame_end,
  output logic                         wr_accept,
  output logic                         overrun,
  output logic                         evt_valid,
  output spi_regs_pkg::wr_evt_t        evt
);

  import spi_regs_pkg::*;

  frame_state_t state_q;
  logic         wr_flag_q; // latched from command bit 7
  reg_addr_t    addr_q;    // address of the byte in flight
  logic         slot_busy; // event slot stays occupied this edge
  logic         evt_load;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q   <= FRAME_IDLE;
      wr_flag_q <= 1'b0;
      addr_q    <= '0;
    end else if (!sel) begin
      state_q   <= FRAME_IDLE; // ss high aborts any frame
      wr_flag_q <= 1'b0;       // next frame starts as a read
    end else begin
      case (state_q)
        FRAME_IDLE: state_q <= FRAME_CMD;
        FRAME_CMD: begin
          if (rx_done) begin
            state_q   <= FRAME_DATA;
            wr_flag_q <= rx_byte[CMD_WR_BIT];
            addr_q    <= rx_byte[3:0]; // bits 6:4 ignored
          end
        end
        FRAME_DATA: begin
          if (rx_done)
            addr_q <= addr_q + 4'd1; // wraps 15 -> 0
        end
        default: state_q <= FRAME_IDLE;
      endcase
    end
  end

  // id goes out during the command byte
  assign rd_addr = (state_q == FRAME_DATA) ? addr_q : ADDR_ID;
  assign tx_byte = rd_addr[3] ? stat_rd_data : file_rd_data;

  assign wr_en     = rx_done && wr_flag_q;
  assign wr        = '{addr: addr_q, data: rx_byte};
  assign wr_accept = wr_en && !addr_q[3]; // only 0..7 are writable
  assign frame_end = (state_q != FRAME_IDLE) && !sel;

  assign slot_busy = evt_valid && !evt_ready;
  assign overrun   = wr_accept && slot_busy;
  assign evt_load  = wr_accept && !slot_busy; // free or draining this edge

  always_ff @(posedge clk) begin
    if (rst)
      evt_valid <= 1'b0;
    else if (evt_load)
      evt_valid <= 1'b1;
    else if (evt_ready)
      evt_valid <= 1'b0; // handshake done
  end

  always_ff @(posedge clk) begin
    if (evt_load)
      evt <= wr;
  end

  // a stalled event holds its value
  a_evt_hold: assert property (@(posedge clk) disable iff (rst)
    evt_valid && !evt_ready |=> evt_valid && $stable(evt));

  // the command byte never reaches the register file
  a_no_wr_in_cmd: assert property (@(posedge clk) disable iff (rst)
    wr_en |-> state_q != FRAME_CMD);

endmodule

`default_nettype wire

// ==== hdl/spi_reg_file.sv ====
// Eight read/write byte registers at addresses 0..7.
// One write port fed by the frame controller, one combinational read port.
// Writes aimed at the upper half of the map are ignored here.
`timescale 1ns/100ps
`default_nettype none

module spi_reg_file (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          wr_en,
  input  wire spi_regs_pkg::wr_evt_t   wr,      // address and data
  input  wire spi_regs_pkg::reg_addr_t rd_addr,
  output spi_regs_pkg::byte_t          rd_data
);

  import spi_regs_pkg::*;

  localparam int NUM_REGS = 8;

  byte_t regs [NUM_REGS]; // register array
  logic  wr_hit;          // write lands in 0..7
  logic  [2:0] wr_idx;
  logic  [2:0] rd_idx;

  assign wr_hit = wr_en && !wr.addr[3];
  assign wr_idx = wr.addr[2:0];
  assign rd_idx = rd_addr[2:0];

  always_ff @(posedge clk) begin
    if (rst)
      regs <= '{default: '0}; // all registers start at zero
    else if (wr_hit)
      regs[wr_idx] <= wr.data;
  end

  // bit 3 is decoded by the frame controller
  assign rd_data = regs[rd_idx];

endmodule

`default_nettype wire

// ==== hdl/spi_regs.sv ====
// Top level of the SPI-attached register block.
// Connects the byte shifter, frame controller, register file and status
// window. DEVICE_ID sets the value returned during every command byte.
`timescale 1ns/100ps
`default_nettype none

module spi_regs #(
  parameter spi_regs_pkg::byte_t DEVICE_ID = 8'ha5
) (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        ss,
  input  wire                        sck,
  input  wire                        mosi,
  input  wire                        evt_ready,
  output wire                        miso,
  output wire                        evt_valid,
  output wire spi_regs_pkg::wr_evt_t evt
);

  import spi_regs_pkg::*;

  wire            sel;
  wire            rx_done;
  wire byte_t     rx_byte;
  wire byte_t     tx_byte;
  wire reg_addr_t rd_addr;      // shared read address
  wire byte_t     file_rd_data;
  wire byte_t     stat_rd_data;
  wire            wr_en;
  wire wr_evt_t   wr;
  wire            frame_end;
  wire            wr_accept;
  wire            overrun;

  spi_byte_io u_byte_io (
    .clk     (clk),
    .rst     (rst),
    .ss      (ss),
    .sck     (sck),
    .mosi    (mosi),
    .tx_byte (tx_byte),
    .miso    (miso),
    .sel     (sel),
    .rx_done (rx_done),
    .rx_byte (rx_byte)
  );

  spi_frame_ctrl u_frame_ctrl (
    .clk          (clk),
    .rst          (rst),
    .sel          (sel),
    .rx_done      (rx_done),
    .rx_byte      (rx_byte),
    .file_rd_data (file_rd_data),
    .stat_rd_data (stat_rd_data),
    .evt_ready    (evt_ready),
    .tx_byte      (tx_byte),
    .rd_addr      (rd_addr),
    .wr_en        (wr_en),
    .wr           (wr),
    .frame_end    (frame_end),
    .wr_accept    (wr_accept),
    .overrun      (overrun),
    .evt_valid    (evt_valid),
    .evt          (evt)
  );

  spi_reg_file u_reg_file (
    .clk     (clk),
    .rst     (rst),
    .wr_en   (wr_en),
    .wr      (wr),
    .rd_addr (rd_addr),
    .rd_data (file_rd_data)
  );

  spi_status_regs #(
    .DEVICE_ID (DEVICE_ID)
  ) u_status_regs (
    .clk       (clk),
    .rst       (rst),
    .frame_end (frame_end),
    .wr_accept (wr_accept),
    .overrun   (overrun),
    .rd_addr   (rd_addr),
    .rd_data   (stat_rd_data)
  );

endmodule

`default_nettype wire

// ==== hdl/spi_regs_pkg.sv ====
// Shared types for the SPI register block.
// Compiled first; modules import it inside their bodies and use scoped
// names in their port lists.
`default_nettype none

package spi_regs_pkg;

  typedef logic [7:0] byte_t;     // one spi data byte
  typedef logic [3:0] reg_addr_t; // register address 0..15

  // write event, also used as the register file write port
  typedef struct packed {
    reg_addr_t addr; // target register
    byte_t     data; // value written
  } wr_evt_t;

  // frame controller states
  typedef enum logic [1:0] {
    FRAME_IDLE = 2'd0, // ss high
    FRAME_CMD  = 2'd1, // waiting for command byte
    FRAME_DATA = 2'd2  // data bytes in flight
  } frame_state_t;

  // status window, upper half of the map
  localparam reg_addr_t ADDR_ID     = 4'd8;  // device id
  localparam reg_addr_t ADDR_FRAMES = 4'd9;  // frame count
  localparam reg_addr_t ADDR_WRITES = 4'd10; // accepted writes
  localparam reg_addr_t ADDR_FLAGS  = 4'd11; // sticky flags

  // command byte fields
  localparam int CMD_WR_BIT = 7; // set for write frames

  // flag register bits
  localparam int FLAG_OVERRUN = 0;

endpackage

`default_nettype wire

// ==== hdl/spi_status_regs.sv ====
// Read-only status window at addresses 8..15.
// Holds the device id, wrapping frame and accepted-write counters and the
// sticky flags. Counters advance on single-cycle pulses from the frame
// controller. Reads are combinational.
`timescale 1ns/100ps
`default_nettype none

module spi_status_regs #(
  parameter spi_regs_pkg::byte_t DEVICE_ID = 8'ha5
) (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          frame_end, // one per finished frame
  input  wire                          wr_accept, // write to 0..7
  input  wire                          overrun,   // event dropped
  input  wire spi_regs_pkg::reg_addr_t rd_addr,
  output spi_regs_pkg::byte_t          rd_data
);

  import spi_regs_pkg::*;

  byte_t frame_cnt; // wraps at 256
  byte_t wr_cnt;    // wraps at 256
  logic  ovr_flag;  // sticky until reset
  byte_t flags;

  always_ff @(posedge clk) begin
    if (rst) begin
      frame_cnt <= '0;
      wr_cnt    <= '0;
      ovr_flag  <= 1'b0;
    end else begin
      if (frame_end)
        frame_cnt <= frame_cnt + 8'd1;
      if (wr_accept)
        wr_cnt <= wr_cnt + 8'd1;
      if (overrun)
        ovr_flag <= 1'b1; // only reset clears it
    end
  end

  always_comb begin
    flags               = '0;
    flags[FLAG_OVERRUN] = ovr_flag;
  end

  // 0..7 and 12..15 read as zero
  always_comb begin
    case (rd_addr)
      ADDR_ID:     rd_data = DEVICE_ID;
      ADDR_FRAMES: rd_data = frame_cnt;
      ADDR_WRITES: rd_data = wr_cnt;
      ADDR_FLAGS:  rd_data = flags;
      default:     rd_data = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== spi_regs.f ====
hdl/spi_regs_pkg.sv
hdl/spi_byte_io.sv
hdl/spi_reg_file.sv
hdl/spi_status_regs.sv
hdl/spi_frame_ctrl.sv
hdl/spi_regs.sv
bench/spi_regs_tb.sv
